/* rtl/decode_pkg.sv */
package decode_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [31:0]           inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [13:0]           alu_op_t;     // one-hot, bit 5 unused
    typedef logic [5:0]            shifter_op_t; // one-hot
    typedef logic [3:0]            mem_size_t;   // byte, half, word, double

    // alu_op_t bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_LUI  = 8;
    localparam int ALU_MUL  = 9;
    localparam int ALU_DIV  = 10;
    localparam int ALU_DIVU = 11;
    localparam int ALU_REM  = 12;
    localparam int ALU_REMU = 13;

    // shifter_op_t bit positions
    localparam int SH_SLL  = 0;
    localparam int SH_SRL  = 1;
    localparam int SH_SRA  = 2;
    localparam int SH_SLLW = 3;
    localparam int SH_SRLW = 4;
    localparam int SH_SRAW = 5;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam xlen_t LINK_OFFSET = 64'd4; // return address offset for jal/jalr

endpackage

/* rtl/decode_stage_reg.sv */
`timescale 1ns/10ps

module decode_stage_reg (
    input  logic                clk,
    input  logic                reset,
    input  logic                fs_to_ds_valid,
    input  decode_pkg::xlen_t   fs_pc,
    input  decode_pkg::inst_t   instruction,
    input  logic                es_allowin,
    input  logic                block1,
    input  logic                block2,
    input  logic                es_load_related1,
    input  logic                es_load_related2,
    input  logic                is_trans,
    output logic                ds_valid,
    output decode_pkg::xlen_t   ds_pc,
    output decode_pkg::inst_t   ds_inst,
    output logic                ds_allowin,
    output logic                ds_to_es_valid,
    output logic                ds_load_block,
    output logic                es_related_cancel,
    output logic                branch_taken_cancel
);

    logic trans_pending; // taken redirect seen, wrong-path fetch still to cancel
    logic accept;

    assign ds_load_block       = block1 | block2;
    assign es_related_cancel   = es_load_related1 | es_load_related2;
    assign ds_allowin          = !ds_valid || (!ds_load_block && es_allowin);
    assign ds_to_es_valid      = ds_valid && !ds_load_block;
    assign accept              = fs_to_ds_valid && ds_allowin;
    assign branch_taken_cancel = (is_trans || trans_pending) && accept;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (branch_taken_cancel) begin
            ds_valid <= 1'b0; // latch the prefetched inst but drop it
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ds_pc   <= fs_pc;
            ds_inst <= instruction;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            trans_pending <= 1'b0;
        end else if (is_trans && !branch_taken_cancel && ds_valid && !ds_load_block) begin
            trans_pending <= 1'b1;
        end else if (accept) begin
            trans_pending <= 1'b0;
        end
    end

endmodule

/* rtl/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
    input  decode_pkg::inst_t         ds_inst,
    output decode_pkg::reg_addr_t     rs1,
    output decode_pkg::reg_addr_t     rs2,
    output decode_pkg::reg_addr_t     rf_dest,
    output logic                      rf_we,
    output decode_pkg::xlen_t         imm,
    output logic                      rs1_used,
    output logic                      rs2_used,
    output decode_pkg::alu_op_t       alu_op,
    output decode_pkg::shifter_op_t   shifter_op,
    output logic                      is_alu,
    output logic                      rwi_type,
    output logic                      load,
    output logic                      loadu,
    output logic                      store,
    output decode_pkg::mem_size_t     dwhb,
    output logic                      use_pc_op1,
    output logic                      op2_sel_reg,
    output logic                      link,
    output logic                      is_jal,
    output logic                      is_jalr,
    output logic [2:0]                br_funct3,
    output logic                      is_branch_op
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [7:0] f3; // one-hot funct3
    logic op_r, op_rw, op_i, op_iw, op_ld, op_st, op_br, op_lui, op_auipc;
    logic f7_base, f7_alt, f7_md;
    logic i_fmt, u_fmt;

    assign opcode    = ds_inst[6:0];
    assign funct7    = ds_inst[31:25];
    assign f3        = 8'b1 << ds_inst[14:12];
    assign rs1       = ds_inst[19:15];
    assign rs2       = ds_inst[24:20];
    assign rf_dest   = ds_inst[11:7];
    assign br_funct3 = ds_inst[14:12];

    assign op_r     = opcode == decode_pkg::OPC_OP;
    assign op_rw    = opcode == decode_pkg::OPC_OP_32;
    assign op_i     = opcode == decode_pkg::OPC_OP_IMM;
    assign op_iw    = opcode == decode_pkg::OPC_OP_IMM_32;
    assign op_ld    = opcode == decode_pkg::OPC_LOAD;
    assign op_st    = opcode == decode_pkg::OPC_STORE;
    assign op_br    = opcode == decode_pkg::OPC_BRANCH;
    assign op_lui   = opcode == decode_pkg::OPC_LUI;
    assign op_auipc = opcode == decode_pkg::OPC_AUIPC;
    assign is_jal   = opcode == decode_pkg::OPC_JAL;
    assign is_jalr  = opcode == decode_pkg::OPC_JALR;

    assign f7_base = funct7 == decode_pkg::F7_BASE;
    assign f7_alt  = funct7 == decode_pkg::F7_ALT;
    assign f7_md   = funct7 == decode_pkg::F7_MULDIV;

    assign i_fmt = op_i || op_iw || op_ld || is_jalr;
    assign u_fmt = op_lui || op_auipc;

    always_comb begin
        if (i_fmt) begin
            imm = {{52{ds_inst[31]}}, ds_inst[31:20]};
        end else if (op_st) begin
            imm = {{52{ds_inst[31]}}, ds_inst[31:25], ds_inst[11:7]};
        end else if (op_br) begin
            imm = {{52{ds_inst[31]}}, ds_inst[7], ds_inst[30:25], ds_inst[11:8], 1'b0};
        end else if (u_fmt) begin
            imm = {{32{ds_inst[31]}}, ds_inst[31:12], 12'b0};
        end else if (is_jal) begin
            imm = {{44{ds_inst[31]}}, ds_inst[19:12], ds_inst[20], ds_inst[30:21], 1'b0};
        end else begin
            imm = '0;
        end
    end

    always_comb begin
        alu_op = '0;
        alu_op[decode_pkg::ALU_ADD] = ((op_r || op_rw) && f7_base && f3[0])
                                   || ((op_i || op_iw) && f3[0])
                                   || op_auipc || is_jal || is_jalr;
        alu_op[decode_pkg::ALU_SUB]  = (op_r || op_rw) && f7_alt && f3[0];
        alu_op[decode_pkg::ALU_SLT]  = (op_r && f7_base && f3[2]) || (op_i && f3[2]);
        alu_op[decode_pkg::ALU_SLTU] = (op_r && f7_base && f3[3]) || (op_i && f3[3]);
        alu_op[decode_pkg::ALU_XOR]  = (op_r && f7_base && f3[4]) || (op_i && f3[4]);
        alu_op[decode_pkg::ALU_OR]   = (op_r && f7_base && f3[6]) || (op_i && f3[6]);
        alu_op[decode_pkg::ALU_AND]  = (op_r && f7_base && f3[7]) || (op_i && f3[7]);
        alu_op[decode_pkg::ALU_LUI]  = op_lui;
        // M extension, W forms share the bits
        alu_op[decode_pkg::ALU_MUL]  = (op_r || op_rw) && f7_md && f3[0];
        alu_op[decode_pkg::ALU_DIV]  = (op_r || op_rw) && f7_md && f3[4];
        alu_op[decode_pkg::ALU_DIVU] = (op_r || op_rw) && f7_md && f3[5];
        alu_op[decode_pkg::ALU_REM]  = (op_r || op_rw) && f7_md && f3[6];
        alu_op[decode_pkg::ALU_REMU] = (op_r || op_rw) && f7_md && f3[7];
    end

    always_comb begin
        shifter_op = '0;
        // 6-bit shamt on rv64, only funct7[6:1] is checked for immediates
        shifter_op[decode_pkg::SH_SLL]  = (op_r && f7_base && f3[1])
                                       || (op_i && f3[1] && funct7[6:1] == 6'b000000);
        shifter_op[decode_pkg::SH_SRL]  = (op_r && f7_base && f3[5])
                                       || (op_i && f3[5] && funct7[6:1] == 6'b000000);
        shifter_op[decode_pkg::SH_SRA]  = (op_r && f7_alt && f3[5])
                                       || (op_i && f3[5] && funct7[6:1] == 6'b010000);
        shifter_op[decode_pkg::SH_SLLW] = (op_rw || op_iw) && f7_base && f3[1];
        shifter_op[decode_pkg::SH_SRLW] = (op_rw || op_iw) && f7_base && f3[5];
        shifter_op[decode_pkg::SH_SRAW] = (op_rw || op_iw) && f7_alt && f3[5];
    end

    assign is_alu   = |alu_op;
    assign rwi_type = op_rw || (op_iw && f3[0]); // W forms plus addiw
    assign rf_we    = !(op_br || op_st);
    assign rs1_used = !(op_lui || op_auipc || is_jal);
    assign rs2_used = op_r || op_rw || op_br || op_st;

    assign load    = op_ld && (f3[0] || f3[1] || f3[2] || f3[3]);
    assign loadu   = op_ld && (f3[4] || f3[5] || f3[6]);
    assign store   = op_st && (f3[0] || f3[1] || f3[2] || f3[3]);
    assign dwhb[0] = (op_ld && (f3[0] || f3[4])) || (op_st && f3[0]);
    assign dwhb[1] = (op_ld && (f3[1] || f3[5])) || (op_st && f3[1]);
    assign dwhb[2] = (op_ld && (f3[2] || f3[6])) || (op_st && f3[2]);
    assign dwhb[3] = (op_ld || op_st) && f3[3];

    assign use_pc_op1   = op_auipc || is_jal || is_jalr;
    assign op2_sel_reg  = op_r || op_rw || op_st;
    assign link         = is_jal || is_jalr;
    assign is_branch_op = op_br;

endmodule

/* rtl/operand_forward.sv */
`timescale 1ns/10ps

module operand_forward (
    input  decode_pkg::reg_addr_t src,
    input  logic                  src_used,
    input  decode_pkg::xlen_t     rf_data,
    input  logic                  es_valid,
    input  logic                  es_rf_we,
    input  decode_pkg::reg_addr_t es_rf_dest,
    input  logic                  es_res_from_mem,
    input  decode_pkg::xlen_t     es_result,
    input  logic                  ms_valid,
    input  logic                  ms_rf_we,
    input  decode_pkg::reg_addr_t ms_rf_dest,
    input  logic                  ms_res_from_mem,
    input  logic                  ms_ls_result_valid,
    input  decode_pkg::xlen_t     ms_final_result,
    input  logic                  ws_valid,
    input  logic                  ws_rf_we,
    input  decode_pkg::reg_addr_t ws_rf_dest,
    input  decode_pkg::xlen_t     ws_final_result,
    output decode_pkg::xlen_t     fwd_data,
    output logic                  es_hit,
    output logic                  block,
    output logic                  es_load_related
);

    logic src_nz;
    logic ms_hit;
    logic ws_hit;

    assign src_nz = src != '0; // x0 never forwards
    assign es_hit = src_nz && es_valid && es_rf_we && (src == es_rf_dest);
    assign ms_hit = src_nz && ms_valid && ms_rf_we && (src == ms_rf_dest);
    assign ws_hit = src_nz && ws_valid && ws_rf_we && (src == ws_rf_dest);

    // youngest producer wins
    assign fwd_data = es_hit ? es_result       :
                      ms_hit ? ms_final_result :
                      ws_hit ? ws_final_result : rf_data;

    assign es_load_related = src_used && es_hit && es_res_from_mem;
    assign block = es_load_related
                || (src_used && ms_hit && ms_res_from_mem && !ms_ls_result_valid);

endmodule

/* rtl/branch_unit.sv */
`timescale 1ns/10ps

module branch_unit (
    input  logic              ds_valid,
    input  decode_pkg::xlen_t ds_pc,
    input  decode_pkg::xlen_t imm,
    input  decode_pkg::xlen_t op1,
    input  decode_pkg::xlen_t op2,
    input  logic              es_hit1,
    input  logic              es_hit2,
    input  logic              es_allowin,
    input  logic              is_jal,
    input  logic              is_jalr,
    input  logic              is_branch_op,
    input  logic [2:0]        br_funct3,
    input  logic              use_pc_op1,
    input  logic              op2_sel_reg,
    input  logic              link,
    output logic              is_trans,
    output decode_pkg::xlen_t trans_addr,
    output decode_pkg::xlen_t oprand1,
    output decode_pkg::xlen_t oprand2,
    output decode_pkg::xlen_t ls_addr
);

    logic              cond;
    logic              es_busy;
    logic              br_taken;
    decode_pkg::xlen_t target;

    always_comb begin
        case (br_funct3)
            3'b000:  cond = op1 == op2;
            3'b001:  cond = op1 != op2;
            3'b100:  cond = $signed(op1) < $signed(op2);
            3'b101:  cond = $signed(op1) >= $signed(op2);
            3'b110:  cond = op1 < op2;
            3'b111:  cond = op1 >= op2;
            default: cond = 1'b0;
        endcase
    end

    // an operand from a multicycle op in execute is not final yet
    assign es_busy  = (es_hit1 || es_hit2) && !es_allowin;
    assign br_taken = is_branch_op && cond && !es_busy;
    assign is_trans = (is_jal || is_jalr || br_taken) && ds_valid;

    assign target     = (is_jalr ? op1 : ds_pc) + imm;
    assign trans_addr = {target[decode_pkg::XLEN-1:2], 2'b00};

    assign oprand1 = use_pc_op1 ? ds_pc : op1;
    assign oprand2 = link        ? decode_pkg::LINK_OFFSET :
                     op2_sel_reg ? op2 : imm;
    assign ls_addr = op1 + imm;

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  decode_pkg::inst_t         instruction,
    input  decode_pkg::xlen_t         fs_pc,
    input  logic                      fs_to_ds_valid,
    input  logic                      es_allowin,
    input  logic                      es_valid,
    input  logic                      ms_valid,
    input  logic                      ws_valid,
    input  logic                      es_rf_we,
    input  logic                      ms_rf_we,
    input  logic                      ws_rf_we,
    input  decode_pkg::reg_addr_t     es_rf_dest,
    input  decode_pkg::reg_addr_t     ms_rf_dest,
    input  decode_pkg::reg_addr_t     ws_rf_dest,
    input  logic                      es_res_from_mem,
    input  logic                      ms_res_from_mem,
    input  logic                      ms_ls_result_valid,
    input  decode_pkg::xlen_t         es_result,
    input  decode_pkg::xlen_t         ms_final_result,
    input  decode_pkg::xlen_t         ws_final_result,
    input  decode_pkg::xlen_t         rf_src1,
    input  decode_pkg::xlen_t         rf_src2,
    output logic                      ds_to_es_valid,
    output logic                      ds_allowin,
    output decode_pkg::xlen_t         ds_pc,
    output decode_pkg::inst_t         ds_inst,
    output decode_pkg::reg_addr_t     rs1,
    output decode_pkg::reg_addr_t     rs2,
    output decode_pkg::reg_addr_t     rf_dest,
    output logic                      rf_we,
    output decode_pkg::xlen_t         oprand1,
    output decode_pkg::xlen_t         oprand2,
    output decode_pkg::alu_op_t       alu_op,
    output decode_pkg::shifter_op_t   shifter_op,
    output logic                      is_alu,
    output logic                      rwi_type,
    output logic                      load,
    output logic                      loadu,
    output logic                      store,
    output decode_pkg::mem_size_t     dwhb,
    output decode_pkg::xlen_t         ls_addr,
    output logic                      ds_load_block,
    output logic                      es_related_cancel,
    output logic                      is_trans,
    output decode_pkg::xlen_t         trans_addr,
    output logic                      branch_taken_cancel
);

    logic              ds_valid;
    logic              block1, block2;
    logic              es_load_related1, es_load_related2;
    logic              es_hit1, es_hit2;
    logic              rs1_used, rs2_used;
    logic              use_pc_op1, op2_sel_reg, link;
    logic              is_jal, is_jalr, is_branch_op;
    logic [2:0]        br_funct3;
    decode_pkg::xlen_t imm;
    decode_pkg::xlen_t op1, op2; // forwarded register values

    decode_stage_reg u_stage_reg (
        .clk, .reset, .fs_to_ds_valid, .fs_pc, .instruction, .es_allowin,
        .block1, .block2, .es_load_related1, .es_load_related2, .is_trans,
        .ds_valid, .ds_pc, .ds_inst, .ds_allowin, .ds_to_es_valid,
        .ds_load_block, .es_related_cancel, .branch_taken_cancel
    );

    inst_decoder u_decoder (
        .ds_inst, .rs1, .rs2, .rf_dest, .rf_we, .imm, .rs1_used, .rs2_used,
        .alu_op, .shifter_op, .is_alu, .rwi_type, .load, .loadu, .store, .dwhb,
        .use_pc_op1, .op2_sel_reg, .link, .is_jal, .is_jalr, .br_funct3, .is_branch_op
    );

    operand_forward u_fwd1 (
        .src(rs1), .src_used(rs1_used), .rf_data(rf_src1),
        .es_valid, .es_rf_we, .es_rf_dest, .es_res_from_mem, .es_result,
        .ms_valid, .ms_rf_we, .ms_rf_dest, .ms_res_from_mem, .ms_ls_result_valid,
        .ms_final_result, .ws_valid, .ws_rf_we, .ws_rf_dest, .ws_final_result,
        .fwd_data(op1), .es_hit(es_hit1), .block(block1), .es_load_related(es_load_related1)
    );

    operand_forward u_fwd2 (
        .src(rs2), .src_used(rs2_used), .rf_data(rf_src2),
        .es_valid, .es_rf_we, .es_rf_dest, .es_res_from_mem, .es_result,
        .ms_valid, .ms_rf_we, .ms_rf_dest, .ms_res_from_mem, .ms_ls_result_valid,
        .ms_final_result, .ws_valid, .ws_rf_we, .ws_rf_dest, .ws_final_result,
        .fwd_data(op2), .es_hit(es_hit2), .block(block2), .es_load_related(es_load_related2)
    );

    branch_unit u_branch (
        .ds_valid, .ds_pc, .imm, .op1, .op2, .es_hit1, .es_hit2, .es_allowin,
        .is_jal, .is_jalr, .is_branch_op, .br_funct3, .use_pc_op1, .op2_sel_reg, .link,
        .is_trans, .trans_addr, .oprand1, .oprand2, .ls_addr
    );

endmodule

/* testbench/tb_inst_enc.svh */
`ifndef TB_INST_ENC_SVH
`define TB_INST_ENC_SVH

logic [31:0] lfsr_state = 32'hf1e8ed48;

// taps 32,22,2,1
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[62:0], lfsr_step()};
    return r;
endfunction

function automatic decode_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic decode_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic decode_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], decode_pkg::OPC_STORE};
endfunction

function automatic decode_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], decode_pkg::OPC_BRANCH};
endfunction

function automatic decode_pkg::inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic decode_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, decode_pkg::OPC_JAL};
endfunction

`endif

/* testbench/tb_decode_stage.sv */
`timescale 1ns/10ps

module tb_decode_stage;

    logic clk, reset, fs_to_ds_valid, es_allowin, es_valid, ms_valid, ws_valid;
    logic es_rf_we, ms_rf_we, ws_rf_we, es_res_from_mem, ms_res_from_mem, ms_ls_result_valid;
    decode_pkg::inst_t instruction;
    decode_pkg::reg_addr_t es_rf_dest, ms_rf_dest, ws_rf_dest;
    decode_pkg::xlen_t fs_pc, es_result, ms_final_result, ws_final_result, rf_src1, rf_src2;
    logic ds_to_es_valid, ds_allowin, rf_we, is_alu, rwi_type, load, loadu, store;
    logic ds_load_block, es_related_cancel, is_trans, branch_taken_cancel;
    decode_pkg::xlen_t ds_pc, oprand1, oprand2, ls_addr, trans_addr;
    decode_pkg::inst_t ds_inst;
    decode_pkg::reg_addr_t rs1, rs2, rf_dest;
    decode_pkg::alu_op_t alu_op;
    decode_pkg::shifter_op_t shifter_op;
    decode_pkg::mem_size_t dwhb;

    decode_pkg::xlen_t pc_cur;
    decode_pkg::reg_addr_t ra, rb, rd;
    logic [11:0] im;

    `include "tb_inst_enc.svh"

    decode_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    function automatic decode_pkg::xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic new_regs();
        ra = 5'(rand_bits(5));
        rb = 5'(rand_bits(5));
        rd = 5'(rand_bits(5));
        if (ra == 0) ra = 5'd1;
        if (rb == 0 || rb == ra) rb = ra + 5'd1; // x31+1 wraps to 0
        if (rb == 0) rb = 5'd2;
        im = 12'(rand_bits(12));
        rf_src1 = rand_bits(64);
        rf_src2 = rand_bits(64);
    endtask

    // offers one instruction and returns one ns after the accepting edge
    task automatic issue(input decode_pkg::inst_t inst);
        int n;
        logic ok;
        n = 0;
        ok = 1'b0;
        pc_cur = pc_cur + 64'd4;
        fs_pc = pc_cur;
        instruction = inst;
        fs_to_ds_valid = 1'b1;
        while (!ok) begin
            #1;
            ok = ds_allowin;
            next_cycle();
            n++;
            if (!ok && n > 20) fail_run("instruction never accepted");
        end
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic check_alu(input string name, input decode_pkg::inst_t inst,
            input int alu_bit, input int sh_bit, input logic rw, input logic imm_form);
        decode_pkg::alu_op_t exp_alu;
        decode_pkg::shifter_op_t exp_sh;
        exp_alu = '0;
        exp_sh = '0;
        if (alu_bit >= 0) exp_alu[alu_bit] = 1'b1;
        if (sh_bit >= 0) exp_sh[sh_bit] = 1'b1;
        issue(inst);
        #1;
        check_val({name, " alu_op"}, 64'(alu_op), 64'(exp_alu));
        check_val({name, " shifter_op"}, 64'(shifter_op), 64'(exp_sh));
        check_val({name, " is_alu"}, 64'(is_alu), 64'(alu_bit >= 0));
        check_val({name, " rwi_type"}, 64'(rwi_type), 64'(rw));
        check_val({name, " rs1"}, 64'(rs1), 64'(ra));
        check_val({name, " rf_dest"}, 64'(rf_dest), 64'(rd));
        check_val({name, " rf_we"}, 64'(rf_we), 64'd1);
        check_val({name, " oprand1"}, oprand1, rf_src1);
        if (!imm_form) check_val({name, " rs2"}, 64'(rs2), 64'(rb));
        check_val({name, " oprand2"}, oprand2, imm_form ? sext12(im) : rf_src2);
        next_cycle();
    endtask

    task automatic check_mem(input string name, input decode_pkg::inst_t inst,
            input logic [2:0] lsu, input logic [3:0] size, input decode_pkg::xlen_t offs);
        issue(inst);
        #1;
        check_val({name, " load"}, 64'(load), 64'(lsu[2]));
        check_val({name, " loadu"}, 64'(loadu), 64'(lsu[1]));
        check_val({name, " store"}, 64'(store), 64'(lsu[0]));
        check_val({name, " dwhb"}, 64'(dwhb), 64'(size));
        check_val({name, " ls_addr"}, ls_addr, rf_src1 + offs);
        check_val({name, " rf_we"}, 64'(rf_we), 64'(!lsu[0]));
        next_cycle();
    endtask

    // held transfer must cancel the prefetched instruction
    task automatic check_transfer(input string name, input decode_pkg::xlen_t target);
        instruction = enc_i(12'd0, 5'd0, 3'd0, 5'd0, decode_pkg::OPC_OP_IMM);
        fs_pc = pc_cur + 64'd4;
        fs_to_ds_valid = 1'b1;
        #1;
        check_val({name, " is_trans"}, 64'(is_trans), 64'd1);
        check_val({name, " trans_addr"}, trans_addr, {target[63:2], 2'b00});
        check_val({name, " branch_taken_cancel"}, 64'(branch_taken_cancel), 64'd1);
        next_cycle();
        fs_to_ds_valid = 1'b0;
        #1;
        check_val({name, " ds_to_es_valid after cancel"}, 64'(ds_to_es_valid), 64'd0);
        next_cycle();
    endtask

    task automatic set_stages(input logic [2:0] v, input logic [2:0] we, input logic [4:0] d);
        {es_valid, ms_valid, ws_valid} = v;
        {es_rf_we, ms_rf_we, ws_rf_we} = we;
        es_rf_dest = d;
        ms_rf_dest = d;
        ws_rf_dest = d;
    endtask

    initial begin
        decode_pkg::inst_t add_i;
        reset = 1'b1;
        {fs_to_ds_valid, es_res_from_mem, ms_res_from_mem, ms_ls_result_valid} = '0;
        es_allowin = 1'b1;
        set_stages(3'b000, 3'b000, 5'd0);
        instruction = '0;
        fs_pc = '0;
        pc_cur = 64'h1000;
        {es_result, ms_final_result, ws_final_result, rf_src1, rf_src2} = '0;
        repeat (4) begin
            next_cycle();
            check_val("ds_to_es_valid in reset", 64'(ds_to_es_valid), 64'd0);
            check_val("branch_taken_cancel in reset", 64'(branch_taken_cancel), 64'd0);
            check_val("ds_allowin in reset", 64'(ds_allowin), 64'd1);
        end
        reset = 1'b0;
        #1;
        check_val("ds_allowin after reset", 64'(ds_allowin), 64'd1);
        next_cycle();

        // handshake and back-pressure
        new_regs();
        issue(enc_i(im, ra, 3'd0, rd, decode_pkg::OPC_OP_IMM));
        es_allowin = 1'b0;
        fs_pc = pc_cur + 64'd4; // next fetch offered while stalled
        fs_to_ds_valid = 1'b1;
        #1;
        check_val("ds_to_es_valid", 64'(ds_to_es_valid), 64'd1);
        check_val("ds_pc", ds_pc, pc_cur);
        check_val("ds_inst", 64'(ds_inst), 64'(enc_i(im, ra, 3'd0, rd, decode_pkg::OPC_OP_IMM)));
        check_val("ds_allowin stalled", 64'(ds_allowin), 64'd0);
        next_cycle();
        check_val("ds_pc held", ds_pc, pc_cur);
        check_val("ds_to_es_valid held", 64'(ds_to_es_valid), 64'd1);
        es_allowin = 1'b1;
        fs_to_ds_valid = 1'b0;

        new_regs();
        check_alu("add", enc_r(decode_pkg::F7_BASE, rb, ra, 3'd0, rd, decode_pkg::OPC_OP),
                  decode_pkg::ALU_ADD, -1, 1'b0, 1'b0);
        new_regs();
        check_alu("sub", enc_r(decode_pkg::F7_ALT, rb, ra, 3'd0, rd, decode_pkg::OPC_OP),
                  decode_pkg::ALU_SUB, -1, 1'b0, 1'b0);
        new_regs();
        check_alu("addi", enc_i(im, ra, 3'd0, rd, decode_pkg::OPC_OP_IMM),
                  decode_pkg::ALU_ADD, -1, 1'b0, 1'b1);
        new_regs();
        check_alu("addiw", enc_i(im, ra, 3'd0, rd, decode_pkg::OPC_OP_IMM_32),
                  decode_pkg::ALU_ADD, -1, 1'b1, 1'b1);
        new_regs();
        check_alu("sraw", enc_r(decode_pkg::F7_ALT, rb, ra, 3'd5, rd, decode_pkg::OPC_OP_32),
                  -1, decode_pkg::SH_SRAW, 1'b1, 1'b0);
        new_regs();
        check_alu("mul", enc_r(decode_pkg::F7_MULDIV, rb, ra, 3'd0, rd, decode_pkg::OPC_OP),
                  decode_pkg::ALU_MUL, -1, 1'b0, 1'b0);
        new_regs();
        check_alu("divu", enc_r(decode_pkg::F7_MULDIV, rb, ra, 3'd5, rd, decode_pkg::OPC_OP),
                  decode_pkg::ALU_DIVU, -1, 1'b0, 1'b0);

        // forwarding priority es, ms, ws
        new_regs();
        es_result = rand_bits(64);
        ms_final_result = rand_bits(64);
        ws_final_result = rand_bits(64);
        issue(enc_r(decode_pkg::F7_BASE, rb, ra, 3'd0, rd, decode_pkg::OPC_OP));
        es_allowin = 1'b0; // keep the add in the stage
        set_stages(3'b111, 3'b111, ra);
        #1;
        check_val("oprand1 from es", oprand1, es_result);
        next_cycle();
        es_rf_we = 1'b0;
        #1;
        check_val("oprand1 from ms", oprand1, ms_final_result);
        next_cycle();
        ms_valid = 1'b0;
        #1;
        check_val("oprand1 from ws", oprand1, ws_final_result);
        next_cycle();
        ws_rf_we = 1'b0;
        #1;
        check_val("oprand1 from rf", oprand1, rf_src1);
        next_cycle();
        set_stages(3'b000, 3'b000, 5'd0);
        es_allowin = 1'b1;
        issue(enc_r(decode_pkg::F7_BASE, rb, 5'd0, 3'd0, rd, decode_pkg::OPC_OP));
        set_stages(3'b111, 3'b111, 5'd0);
        #1;
        check_val("oprand1 for x0", oprand1, rf_src1);
        next_cycle();
        set_stages(3'b000, 3'b000, 5'd0);

        // load-use stall
        new_regs();
        add_i = enc_r(decode_pkg::F7_BASE, rb, ra, 3'd0, rd, decode_pkg::OPC_OP);
        issue(add_i);
        set_stages(3'b100, 3'b100, rb);
        es_res_from_mem = 1'b1;
        #1;
        check_val("ds_load_block es load", 64'(ds_load_block), 64'd1);
        check_val("es_related_cancel", 64'(es_related_cancel), 64'd1);
        check_val("ds_to_es_valid es load", 64'(ds_to_es_valid), 64'd0);
        next_cycle();
        set_stages(3'b010, 3'b010, rb);
        es_res_from_mem = 1'b0;
        ms_res_from_mem = 1'b1;
        ms_final_result = rand_bits(64);
        #1;
        check_val("ds_load_block ms load", 64'(ds_load_block), 64'd1);
        check_val("ds_to_es_valid ms load", 64'(ds_to_es_valid), 64'd0);
        next_cycle();
        ms_ls_result_valid = 1'b1;
        #1;
        check_val("ds_load_block ms data", 64'(ds_load_block), 64'd0);
        check_val("ds_to_es_valid ms data", 64'(ds_to_es_valid), 64'd1);
        check_val("oprand2 from ms load", oprand2, ms_final_result);
        next_cycle();
        set_stages(3'b000, 3'b000, 5'd0);
        {ms_res_from_mem, ms_ls_result_valid} = '0;

        new_regs();
        check_mem("ld", enc_i(im, ra, 3'd3, rd, decode_pkg::OPC_LOAD), 3'b100, 4'b1000, sext12(im));
        new_regs();
        check_mem("lbu", enc_i(im, ra, 3'd4, rd, decode_pkg::OPC_LOAD), 3'b010, 4'b0001, sext12(im));
        new_regs();
        check_mem("sh", enc_s(im, rb, ra, 3'd1), 3'b001, 4'b0010, sext12(im));
        new_regs();
        check_mem("sw", enc_s(im, rb, ra, 3'd2), 3'b001, 4'b0100, sext12(im));

        // branches and jumps
        new_regs();
        rf_src2 = rf_src1;
        issue(enc_b({im, 1'b0}, rb, ra, 3'd0));
        check_transfer("beq", pc_cur + {{51{im[11]}}, im, 1'b0});
        issue(enc_b({im, 1'b0}, rb, ra, 3'd1));
        #1;
        check_val("bne is_trans", 64'(is_trans), 64'd0);
        next_cycle();
        issue(enc_j({8'd0, im, 1'b0}, rd));
        #1;
        check_val("jal oprand1", oprand1, pc_cur);
        check_val("jal oprand2", oprand2, 64'd4);
        next_cycle();
        // redirect memory drops a late wrong-path fetch
        issue(enc_i(12'd0, 5'd0, 3'd0, 5'd0, decode_pkg::OPC_OP_IMM));
        #1;
        check_val("ds_to_es_valid late fetch", 64'(ds_to_es_valid), 64'd0);
        next_cycle();
        issue(enc_j({8'd0, im, 1'b0}, rd));
        check_transfer("jal", pc_cur + {51'd0, im, 1'b0});
        new_regs();
        issue(enc_i(im, ra, 3'd0, rd, decode_pkg::OPC_JALR));
        check_transfer("jalr", rf_src1 + sext12(im));

        $display("All checks passed");
        $finish;
    end

endmodule

/* tb.f */
rtl/decode_pkg.sv
rtl/decode_stage_reg.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/decode_stage.sv
+incdir+testbench
testbench/tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_decode_stage -o sim_decode
./obj_dir/sim_decode
